//--- vlog.f
+incdir+logic
+incdir+testbench
logic/tiny86_bus_pkg.sv
logic/tiny86_isa_pkg.sv
logic/tiny86_decoder.sv
logic/tiny86_alu.sv
logic/tiny86_core.sv
logic/tiny86_memory.sv
logic/tiny86_system.sv
testbench/tiny86_tb.sv

//--- testbench/tiny86_tests.svh
`ifndef TINY86_TESTS_SVH
`define TINY86_TESTS_SVH

// instruction words built from the field layout
function automatic tiny86_bus_pkg::word_t mov_word(input logic dp, input logic [2:0] dest,
                                                   input logic [3:0] src,
                                                   input logic [3:0] adder);
    return {dp, dest, src, tiny86_isa_pkg::OP_MOV, adder};
endfunction

function automatic tiny86_bus_pkg::word_t one_word(input logic [2:0] r, input logic [3:0] op,
                                                   input logic [3:0] v);
    return {1'b0, r, op, tiny86_isa_pkg::OP_ONE, v};
endfunction

function automatic tiny86_bus_pkg::word_t br_word(input logic [7:0] offset, input logic neg,
                                                  input tiny86_isa_pkg::cond_t c);
    return {offset, tiny86_isa_pkg::OP_BR, neg, c};
endfunction

function automatic tiny86_bus_pkg::word_t jmp_word(input logic neg,
                                                   input tiny86_isa_pkg::cond_t c);
    return {8'h00, tiny86_isa_pkg::OP_JMP, neg, c};
endfunction

// reference behavior of the one-operand sub-ops
function automatic tiny86_bus_pkg::word_t one_op_model(input logic [3:0] op,
                                                       input tiny86_bus_pkg::word_t x,
                                                       input logic [3:0] v);
    tiny86_bus_pkg::word_t r;
    r = x;
    case (op)
        4'd0: r = x + v;
        4'd1: r = x - v;
        4'd2: r = 16'd0 - x;
        4'd3: r = ~x;
        4'd4: r = x << v;
        4'd5: r = x >> v;
        4'd6: for (int i = 0; i < v; i++) r = {r[14:0], r[15]};
        4'd7: for (int i = 0; i < v; i++) r = {r[0], r[15:1]};
        default: r = x;
    endcase
    return r;
endfunction

// flags left by a mov of src plus adder
function automatic tiny86_isa_pkg::flags_t mov_flags(input tiny86_bus_pkg::word_t src,
                                                     input logic [3:0] adder);
    tiny86_bus_pkg::word_t  sum;
    tiny86_isa_pkg::flags_t f;
    sum = src + 16'(adder);
    f.z = sum == 16'd0;
    f.n = sum[15];
    // carry when the sum wrapped past ffff
    f.c = sum < src;
    return f;
endfunction

function automatic bit cond_holds(input tiny86_isa_pkg::flags_t f,
                                  input tiny86_isa_pkg::cond_t c, input bit neg);
    bit raw;
    case (c)
        tiny86_isa_pkg::COND_ALWAYS: raw = 1'b1;
        tiny86_isa_pkg::COND_Z:      raw = f.z;
        tiny86_isa_pkg::COND_N:      raw = f.n;
        tiny86_isa_pkg::COND_C:      raw = f.c;
        default:                     raw = 1'b0;
    endcase
    return raw ^ neg;
endfunction

task automatic start_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic emit(input tiny86_bus_pkg::word_t w);
    prog.push_back(w);
endtask

task automatic emit_mov_imm(input logic [2:0] dest, input tiny86_bus_pkg::word_t imm,
                            input logic [3:0] adder);
    emit(mov_word(1'b0, dest, 4'b1000, adder));
    emit(imm);
endtask

task automatic emit_store_imm(input logic [2:0] ptr, input tiny86_bus_pkg::word_t imm);
    emit(mov_word(1'b1, ptr, 4'b1000, 4'd0));
    emit(imm);
endtask

task automatic expect_write(input tiny86_bus_pkg::addr_t a, input tiny86_bus_pkg::word_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
endtask

// load under reset, release, wait for hlt, then compare the stores
task automatic run_program(input string name, input bit expect_err);
    int cycles;
    int limit;
    cycles = 0;
    limit  = prog.size() * WORD_CYCLES;
    budget += limit + prog.size() + RESET_CYCLES + SETTLE_CYCLES + 4;
    reset = 1'b0;
    foreach (prog[i]) begin
        load_en   = 1'b1;
        load_addr = tiny86_bus_pkg::addr_t'(i);
        load_data = prog[i];
        next_cycle();
        cycles++;
    end
    load_en = 1'b0;
    while (cycles < RESET_CYCLES) begin
        next_cycle();
        cycles++;
    end
    got_addr.delete();
    got_data.delete();
    capture = 1'b1;
    reset   = 1'b1;
    cycles  = 0;
    while (!hlt && cycles < limit) begin
        next_cycle();
        cycles++;
    end
    if (!hlt) begin
        other_errors++;
        $display("%s: hlt did not rise within %0d cycles", name, limit);
    end else begin
        // extra cycles catch any store after the stop
        repeat (SETTLE_CYCLES) next_cycle();
        if (!hlt) begin
            other_errors++;
            $display("%s: hlt dropped after it had risen", name);
        end
        if (error !== expect_err) begin
            other_errors++;
            $display("%s: error flag is %b but should be %b", name, error, expect_err);
        end
    end
    capture = 1'b0;
    compare_writes(name);
endtask

task automatic compare_writes(input string name);
    int n;
    if (got_addr.size() != exp_addr.size()) begin
        other_errors++;
        $display("%s: expected %0d writes but saw %0d", name, exp_addr.size(), got_addr.size());
    end
    n = got_addr.size() < exp_addr.size() ? got_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
        check_addr($sformatf("%s write %0d address", name, i), got_addr[i], exp_addr[i]);
        check_word($sformatf("%s write %0d data", name, i), got_data[i], exp_data[i]);
    end
endtask

task automatic test_mov_imm();
    logic [31:0]           rnd;
    tiny86_bus_pkg::word_t sum [0:5];
    start_program();
    for (int r = 0; r < 6; r++) begin
        rnd = $random(seed);
        emit_mov_imm(3'(r), rnd[15:0], rnd[19:16]);
        sum[r] = rnd[15:0] + rnd[19:16];
    end
    // r6 as pointer, store each register unchanged
    for (int r = 0; r < 6; r++) begin
        emit_mov_imm(3'd6, 16'h0080 + 16'(r), 4'd0);
        emit(mov_word(1'b1, 3'd6, {1'b0, 3'(r)}, 4'd0));
        expect_write(16'h0080 + 16'(r), sum[r]);
    end
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("mov_imm", 1'b0);
endtask

task automatic test_mov_indirect();
    logic [31:0]           rnd;
    tiny86_bus_pkg::word_t v;
    logic [3:0]            a;
    start_program();
    for (int k = 0; k < 3; k++) begin
        rnd = $random(seed);
        v   = rnd[15:0];
        a   = rnd[19:16];
        emit_mov_imm(3'd1, 16'h0090 + 16'(k), 4'd0);
        emit_store_imm(3'd1, v);
        expect_write(16'h0090 + 16'(k), v);
        // memory to memory through r1 and r2
        emit_mov_imm(3'd2, 16'h00a0 + 16'(k), 4'd0);
        emit(mov_word(1'b1, 3'd2, 4'b1001, 4'd0));
        expect_write(16'h00a0 + 16'(k), v);
        // pointer read into r3 with an adder
        emit(mov_word(1'b0, 3'd3, 4'b1001, a));
        emit_mov_imm(3'd4, 16'h00b0 + 16'(k), 4'd0);
        emit(mov_word(1'b1, 3'd4, 4'b0011, 4'd0));
        expect_write(16'h00b0 + 16'(k), v + a);
    end
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("mov_indirect", 1'b0);
endtask

task automatic test_one_operand();
    logic [31:0] rnd;
    start_program();
    for (int op = 0; op < 8; op++) begin
        rnd = $random(seed);
        emit_mov_imm(3'd5, rnd[15:0], 4'd0);
        emit(one_word(3'd5, 4'(op), rnd[19:16]));
        emit_mov_imm(3'd6, 16'h00c0 + 16'(op), 4'd0);
        emit(mov_word(1'b1, 3'd6, 4'b0101, 4'd0));
        expect_write(16'h00c0 + 16'(op), one_op_model(4'(op), rnd[15:0], rnd[19:16]));
    end
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("one_operand", 1'b0);
endtask

// one marker store per case shows the path that ran
task automatic branch_case(input bit use_jmp, input tiny86_isa_pkg::cond_t c, input bit neg,
                           input bit flag_on, input tiny86_bus_pkg::addr_t mark, input int k);
    tiny86_bus_pkg::word_t imm;
    logic [3:0]            adder;
    tiny86_bus_pkg::word_t not_taken;
    tiny86_bus_pkg::word_t taken;
    int                    base;
    adder     = 4'd0;
    not_taken = 16'h4e00 | 16'(k);
    taken     = 16'h7a00 | 16'(k);
    // each flag_on value sets only the flag under test
    case (c)
        tiny86_isa_pkg::COND_Z: imm = flag_on ? 16'h0000 : 16'h0001;
        tiny86_isa_pkg::COND_N: imm = flag_on ? 16'h8000 : 16'h0001;
        default: begin
            imm   = flag_on ? 16'hffff : 16'h0001;
            adder = flag_on ? 4'd2 : 4'd0;
        end
    endcase
    emit_mov_imm(3'd6, mark, 4'd0);
    // flags come from this mov, right before the branch
    emit_mov_imm(3'd0, imm, adder);
    base = prog.size();
    if (use_jmp) begin
        emit(jmp_word(neg, c));
        emit(tiny86_bus_pkg::word_t'(base + 6));
        emit_store_imm(3'd6, not_taken);
        emit(jmp_word(1'b0, tiny86_isa_pkg::COND_ALWAYS));
        emit(tiny86_bus_pkg::word_t'(base + 8));
        emit_store_imm(3'd6, taken);
    end else begin
        emit(br_word(8'd3, neg, c));
        emit_store_imm(3'd6, not_taken);
        emit(br_word(8'd2, 1'b0, tiny86_isa_pkg::COND_ALWAYS));
        emit_store_imm(3'd6, taken);
    end
    expect_write(mark, cond_holds(mov_flags(imm, adder), c, neg) ? taken : not_taken);
endtask

task automatic test_branches();
    tiny86_isa_pkg::cond_t c;
    start_program();
    for (int k = 0; k < 6; k++) begin
        c = tiny86_isa_pkg::cond_t'(1 + k / 2);
        branch_case(1'b0, c, k[0], 1'b1, 16'h00e0 + 16'(k), k);
        branch_case(1'b1, c, k[0], 1'b0, 16'h00e8 + 16'(k), k + 8);
    end
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("branches", 1'b0);
endtask

task automatic test_halt();
    start_program();
    emit_mov_imm(3'd6, 16'h00f0, 4'd0);
    emit_store_imm(3'd6, 16'h1234);
    expect_write(16'h00f0, 16'h1234);
    emit(tiny86_isa_pkg::SYS_NOP);
    emit(tiny86_isa_pkg::SYS_HALT);
    emit_store_imm(3'd6, 16'hdead);
    run_program("halt", 1'b0);
endtask

task automatic test_errors();
    start_program();
    emit_mov_imm(3'd6, 16'h00f1, 4'd0);
    emit_store_imm(3'd6, 16'h1111);
    expect_write(16'h00f1, 16'h1111);
    // opcode 2 is not defined
    emit(16'h0020);
    emit_store_imm(3'd6, 16'h2222);
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("undefined_opcode", 1'b1);

    start_program();
    emit_mov_imm(3'd6, 16'h00f2, 4'd0);
    emit_store_imm(3'd6, 16'h3333);
    expect_write(16'h00f2, 16'h3333);
    // one-operand inc with the reserved bit 15 set
    emit(16'h8081);
    emit_store_imm(3'd6, 16'h4444);
    emit(tiny86_isa_pkg::SYS_HALT);
    run_program("one_operand_bit15", 1'b1);
endtask

`endif

//--- testbench/tiny86_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny86_config.svh"

module tiny86_tb;

    localparam int ACCESS_CYCLES = `TINY86_MEM_WAIT + 1;
    // cycles allowed per program word, twenty bus accesses each
    localparam int WORD_CYCLES   = 20 * ACCESS_CYCLES;
    localparam int RESET_CYCLES  = 8;
    localparam int SETTLE_CYCLES = 4 * ACCESS_CYCLES;

    logic                  clk;
    logic                  reset;
    logic                  load_en;
    tiny86_bus_pkg::addr_t load_addr;
    tiny86_bus_pkg::word_t load_data;
    logic                  hlt;
    logic                  error;
    logic                  bus_wr;
    tiny86_bus_pkg::addr_t bus_address;
    tiny86_bus_pkg::word_t bus_data;

    // program image and write events, expected and observed
    tiny86_bus_pkg::word_t prog [$];
    tiny86_bus_pkg::addr_t exp_addr [$];
    tiny86_bus_pkg::word_t exp_data [$];
    tiny86_bus_pkg::addr_t got_addr [$];
    tiny86_bus_pkg::word_t got_data [$];

    logic   capture;
    logic   wr_prev;
    integer seed;
    int     value_errors;
    int     other_errors;
    int     budget;
    int     cycles_used;

    tiny86_system u_tiny86_system (
        .clk         (clk),
        .reset       (reset),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .hlt         (hlt),
        .error       (error),
        .bus_wr      (bus_wr),
        .bus_address (bus_address),
        .bus_data    (bus_data)
    );

    always #50 clk = ~clk;

    // one event per store, taken on the rising write strobe
    always @(negedge clk) begin
        if (capture && bus_wr && !wr_prev) begin
            got_addr.push_back(bus_address);
            got_data.push_back(bus_data);
        end
        wr_prev = bus_wr;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_word(input string what, input tiny86_bus_pkg::word_t got,
                              input tiny86_bus_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input tiny86_bus_pkg::addr_t got,
                              input tiny86_bus_pkg::addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    `include "tiny86_tests.svh"

    // ends the run if the tests overrun their summed cycle budget
    initial begin
        while (cycles_used <= budget) begin
            @(posedge clk);
            cycles_used++;
        end
        $display("watchdog: the run went past its budget of %0d cycles", budget);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        capture      = 1'b0;
        wr_prev      = 1'b0;
        seed         = 4058;
        value_errors = 0;
        other_errors = 0;
        budget       = 64;
        cycles_used  = 0;

        next_cycle();
        test_mov_imm();
        test_mov_indirect();
        test_one_operand();
        test_branches();
        test_halt();
        test_errors();

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/tiny86_system.sv
`timescale 1ns/1ps
`default_nettype none

module tiny86_system (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_en,
    input  tiny86_bus_pkg::addr_t load_addr,
    input  tiny86_bus_pkg::word_t load_data,
    output logic                  hlt,
    output logic                  error,
    output logic                  bus_wr,
    output tiny86_bus_pkg::addr_t bus_address,
    output tiny86_bus_pkg::word_t bus_data
);
    tiny86_bus_pkg::addr_t address;
    tiny86_bus_pkg::word_t data_out;
    tiny86_bus_pkg::word_t data_in;
    logic                  rd;
    logic                  wr;
    logic                  ready;

    tiny86_core u_core (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .ready    (ready),
        .address  (address),
        .data_out (data_out),
        .rd       (rd),
        .wr       (wr),
        .hlt      (hlt),
        .error    (error)
    );

    tiny86_memory u_memory (
        .clk       (clk),
        .reset     (reset),
        .address   (address),
        .data_out  (data_out),
        .rd        (rd),
        .wr        (wr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .data_in   (data_in),
        .ready     (ready)
    );

    // write side of the bus for observation
    assign bus_wr      = wr;
    assign bus_address = address;
    assign bus_data    = data_out;

endmodule

`default_nettype wire

//--- logic/tiny86_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny86_config.svh"

module tiny86_memory (
    input  logic                  clk,
    input  logic                  reset,
    input  tiny86_bus_pkg::addr_t address,
    input  tiny86_bus_pkg::word_t data_out,
    input  logic                  rd,
    input  logic                  wr,
    input  logic                  load_en,
    input  tiny86_bus_pkg::addr_t load_addr,
    input  tiny86_bus_pkg::word_t load_data,
    output tiny86_bus_pkg::word_t data_in,
    output logic                  ready
);
    localparam int ADDR_BITS = $clog2(`TINY86_MEM_WORDS);

    tiny86_bus_pkg::word_t mem [0:`TINY86_MEM_WORDS-1];
    logic [7:0]            wait_cnt;
    logic                  access;

    assign access = rd || wr;

    // one-cycle ready pulse after the wait count
    always_ff @(posedge clk) begin
        if (!reset) begin
            ready    <= 1'b0;
            wait_cnt <= 8'd0;
        end else if (ready || !access) begin
            ready    <= 1'b0;
            wait_cnt <= 8'd0;
        end else if (wait_cnt == 8'(`TINY86_MEM_WAIT - 1)) begin
            ready    <= 1'b1;
            wait_cnt <= 8'd0;
        end else begin
            wait_cnt <= wait_cnt + 8'd1;
        end
    end

    // load port only while the core is held in reset
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (load_en) begin
                mem[load_addr[ADDR_BITS-1:0]] <= load_data;
            end
        end else if (ready && wr) begin
            mem[address[ADDR_BITS-1:0]] <= data_out;
        end
    end

    // address is stable during the wait, so this is valid with ready
    always_ff @(posedge clk) begin
        if (rd) begin
            data_in <= mem[address[ADDR_BITS-1:0]];
        end
    end

    a_ready_needs_strobe: assert property (@(posedge clk) disable iff (!reset)
        $rose(ready) |-> $past(access));

endmodule

`default_nettype wire

//--- logic/tiny86_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "tiny86_config.svh"

module tiny86_core (
    input  logic                  clk,
    input  logic                  reset,
    input  tiny86_bus_pkg::word_t data_in,
    input  logic                  ready,
    output tiny86_bus_pkg::addr_t address,
    output tiny86_bus_pkg::word_t data_out,
    output logic                  rd,
    output logic                  wr,
    output logic                  hlt,
    output logic                  error
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_WORD2,
        S_OPER,
        S_STORE,
        S_WB,
        S_STOP
    } stage_t;

    stage_t                   stage;
    tiny86_bus_pkg::word_t    regs [0:7];
    tiny86_bus_pkg::word_t    ir;
    // second word or word read through a pointer
    tiny86_bus_pkg::word_t    operand;
    tiny86_isa_pkg::flags_t   flags;

    tiny86_isa_pkg::opcode_t  opcode;
    tiny86_isa_pkg::cond_t    cond;
    logic                     cond_neg;
    logic [3:0]               value;
    tiny86_isa_pkg::reg_idx_t dest_reg;
    tiny86_isa_pkg::reg_idx_t src_reg;
    logic                     dest_p;
    logic                     src_p;
    logic                     src_imm;
    tiny86_isa_pkg::alu_op_t  alu_op;
    logic                     is_halt;
    logic                     is_nop;
    logic                     is_br;
    logic                     is_jmp;
    logic                     is_mov;
    logic                     is_one;
    logic                     is_err;
    logic                     two_words;

    tiny86_isa_pkg::alu_op_t  alu_sel;
    tiny86_bus_pkg::word_t    src_val;
    tiny86_bus_pkg::word_t    alu_in;
    tiny86_bus_pkg::word_t    alu_result;
    tiny86_isa_pkg::flags_t   alu_flags;
    tiny86_bus_pkg::word_t    br_target;
    logic                     cond_raw;
    logic                     take;

    tiny86_decoder u_decoder (
        .instruction (ir),
        .opcode      (opcode),
        .cond        (cond),
        .cond_neg    (cond_neg),
        .value       (value),
        .dest_reg    (dest_reg),
        .src_reg     (src_reg),
        .dest_p      (dest_p),
        .src_p       (src_p),
        .src_imm     (src_imm),
        .alu_op      (alu_op),
        .is_halt     (is_halt),
        .is_nop      (is_nop),
        .is_br       (is_br),
        .is_jmp      (is_jmp),
        .is_mov      (is_mov),
        .is_one      (is_one),
        .is_err      (is_err),
        .two_words   (two_words)
    );

    // mov is the source plus the adder, so it runs as inc
    assign src_val = (src_imm || src_p) ? operand : regs[src_reg];
    assign alu_sel = is_mov ? tiny86_isa_pkg::ALU_INC : alu_op;
    assign alu_in  = is_mov ? src_val : regs[dest_reg];

    tiny86_alu u_alu (
        .op      (alu_sel),
        .operand (alu_in),
        .value   (value),
        .result  (alu_result),
        .flags   (alu_flags)
    );

    always_comb begin
        case (cond)
            tiny86_isa_pkg::COND_ALWAYS: cond_raw = 1'b1;
            tiny86_isa_pkg::COND_Z:      cond_raw = flags.z;
            tiny86_isa_pkg::COND_N:      cond_raw = flags.n;
            tiny86_isa_pkg::COND_C:      cond_raw = flags.c;
            default:                     cond_raw = 1'b0;
        endcase
    end

    assign take = cond_raw ^ cond_neg;

    // br offset sits in the high byte, pc already past the fetch
    assign br_target = regs[tiny86_isa_pkg::PC_REG] + {{8{ir[15]}}, ir[15:8]};

    // bus outputs follow the stage, so they hold while ready is low
    always_comb begin
        case (stage)
            S_OPER:  address = regs[src_reg];
            S_STORE: address = regs[dest_reg];
            default: address = regs[tiny86_isa_pkg::PC_REG];
        endcase
    end

    assign rd       = stage == S_FETCH || stage == S_WORD2 || stage == S_OPER;
    assign wr       = stage == S_STORE;
    assign data_out = alu_result;

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= S_IDLE;
            hlt   <= 1'b0;
            error <= 1'b0;
            flags <= '0;
            regs[tiny86_isa_pkg::PC_REG] <= `TINY86_RESET_PC;
        end else begin
            case (stage)
                S_IDLE: stage <= S_FETCH;
                S_FETCH: begin
                    if (ready) begin
                        ir <= data_in;
                        regs[tiny86_isa_pkg::PC_REG] <= regs[tiny86_isa_pkg::PC_REG] + 16'd1;
                        stage <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (is_halt || is_err) begin
                        hlt   <= 1'b1;
                        error <= is_err;
                        stage <= S_STOP;
                    end else if (is_nop) begin
                        stage <= S_FETCH;
                    end else if (two_words) begin
                        stage <= S_WORD2;
                    end else if (is_mov && src_p) begin
                        stage <= S_OPER;
                    end else if (is_mov && dest_p) begin
                        stage <= S_STORE;
                    end else begin
                        stage <= S_WB;
                    end
                end
                S_WORD2: begin
                    if (ready) begin
                        operand <= data_in;
                        regs[tiny86_isa_pkg::PC_REG] <= regs[tiny86_isa_pkg::PC_REG] + 16'd1;
                        stage <= (is_mov && dest_p) ? S_STORE : S_WB;
                    end
                end
                S_OPER: begin
                    if (ready) begin
                        operand <= data_in;
                        stage   <= dest_p ? S_STORE : S_WB;
                    end
                end
                S_STORE: begin
                    if (ready) begin
                        stage <= S_WB;
                    end
                end
                S_WB: begin
                    if ((is_br || is_jmp) && take) begin
                        regs[tiny86_isa_pkg::PC_REG] <= is_br ? br_target : operand;
                    end
                    if (is_one || (is_mov && !dest_p)) begin
                        regs[dest_reg] <= alu_result;
                    end
                    // branches only read the flags
                    if (opcode == tiny86_isa_pkg::OP_MOV || opcode == tiny86_isa_pkg::OP_ONE) begin
                        flags <= alu_flags;
                    end
                    stage <= S_FETCH;
                end
                S_STOP: stage <= S_STOP;
                default: stage <= S_IDLE;
            endcase
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(rd && wr));

    // a waiting access keeps its address and strobe until ready
    a_addr_hold: assert property (@(posedge clk) disable iff (!reset)
        (rd || wr) && !ready |=> $stable(address) && $stable({rd, wr}));

endmodule

`default_nettype wire

//--- logic/tiny86_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tiny86_alu (
    input  tiny86_isa_pkg::alu_op_t op,
    input  tiny86_bus_pkg::word_t   operand,
    input  logic [3:0]              value,
    output tiny86_bus_pkg::word_t   result,
    output tiny86_isa_pkg::flags_t  flags
);
    logic [16:0] add_w;
    logic [16:0] sub_w;
    logic [16:0] shl_w;
    logic [16:0] shr_w;
    logic [31:0] rol_w;
    logic [31:0] ror_w;
    logic        carry;

    // bit 16 holds carry or borrow
    assign add_w = {1'b0, operand} + {13'd0, value};
    assign sub_w = {1'b0, operand} - {13'd0, value};

    // last bit out ends up in the extra position
    assign shl_w = {1'b0, operand} << value;
    assign shr_w = {operand, 1'b0} >> value;

    // doubled word makes rotates plain shifts
    assign rol_w = {operand, operand} << value;
    assign ror_w = {operand, operand} >> value;

    always_comb begin
        carry  = 1'b0;
        result = operand;
        case (op)
            tiny86_isa_pkg::ALU_INC: {carry, result} = add_w;
            tiny86_isa_pkg::ALU_DEC: {carry, result} = sub_w;
            tiny86_isa_pkg::ALU_NEG: result = ~operand + 16'd1;
            tiny86_isa_pkg::ALU_NOT: result = ~operand;
            tiny86_isa_pkg::ALU_SHL: {carry, result} = shl_w;
            tiny86_isa_pkg::ALU_SHR: {result, carry} = shr_w;
            tiny86_isa_pkg::ALU_ROL: result = rol_w[31:16];
            tiny86_isa_pkg::ALU_ROR: result = ror_w[15:0];
            default: result = operand;
        endcase
    end

    assign flags = '{z: result == 16'd0, n: result[15], c: carry};

endmodule

`default_nettype wire

//--- logic/tiny86_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tiny86_decoder (
    input  tiny86_bus_pkg::word_t    instruction,
    output tiny86_isa_pkg::opcode_t  opcode,
    output tiny86_isa_pkg::cond_t    cond,
    output logic                     cond_neg,
    output logic [3:0]               value,
    output tiny86_isa_pkg::reg_idx_t dest_reg,
    output tiny86_isa_pkg::reg_idx_t src_reg,
    output logic                     dest_p,
    output logic                     src_p,
    output logic                     src_imm,
    output tiny86_isa_pkg::alu_op_t  alu_op,
    output logic                     is_halt,
    output logic                     is_nop,
    output logic                     is_br,
    output logic                     is_jmp,
    output logic                     is_mov,
    output logic                     is_one,
    output logic                     is_err,
    output logic                     two_words
);
    logic sys_word;
    logic cond_ok;

    // low byte is opcode plus condition or adder
    assign opcode   = instruction[7:4];
    assign cond     = instruction[2:0];
    assign cond_neg = instruction[3];
    assign value    = instruction[3:0];

    // high byte carries the register fields
    assign dest_p   = instruction[15];
    assign dest_reg = instruction[14:12];
    assign src_reg  = instruction[10:8];
    assign src_imm  = instruction[11:8] == 4'b1000;
    // 1xxx with xxx nonzero reads through register xxx
    assign src_p    = instruction[11] && !src_imm;

    // out of range sub-ops are caught by is_one below
    assign alu_op = tiny86_isa_pkg::alu_op_t'(instruction[11:8]);

    assign sys_word = opcode == tiny86_isa_pkg::OP_SYS;
    // only always, z, n and c are defined
    assign cond_ok  = !instruction[2];

    assign is_halt = sys_word && instruction == tiny86_isa_pkg::SYS_HALT;
    assign is_nop  = sys_word && instruction == tiny86_isa_pkg::SYS_NOP;
    assign is_br   = opcode == tiny86_isa_pkg::OP_BR && cond_ok;
    assign is_jmp  = opcode == tiny86_isa_pkg::OP_JMP && cond_ok;
    assign is_mov  = opcode == tiny86_isa_pkg::OP_MOV;

    // bit 15 reserved, sub-op must be one of the eight
    assign is_one = opcode == tiny86_isa_pkg::OP_ONE
                    && !instruction[15]
                    && !instruction[11];

    assign is_err = !(is_halt || is_nop || is_br || is_jmp || is_mov || is_one);

    // jump target or immediate follows in the next word
    assign two_words = is_jmp || (is_mov && src_imm);

endmodule

`default_nettype wire

//--- logic/tiny86_isa_pkg.sv
`default_nettype none

package tiny86_isa_pkg;

    // register file index, r7 doubles as program counter
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t PC_REG = 3'd7;

    // major opcode in bits 7:4
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_SYS = 4'h0;
    localparam opcode_t OP_BR  = 4'h1;
    localparam opcode_t OP_JMP = 4'h3;
    localparam opcode_t OP_MOV = 4'h7;
    localparam opcode_t OP_ONE = 4'h8;

    // one-operand sub-ops in bits 11:8
    typedef enum logic [3:0] {
        ALU_INC = 4'd0,
        ALU_DEC = 4'd1,
        ALU_NEG = 4'd2,
        ALU_NOT = 4'd3,
        ALU_SHL = 4'd4,
        ALU_SHR = 4'd5,
        ALU_ROL = 4'd6,
        ALU_ROR = 4'd7
    } alu_op_t;

    // branch conditions, bit 3 of the word negates
    typedef logic [2:0] cond_t;

    localparam cond_t COND_ALWAYS = 3'd0;
    localparam cond_t COND_Z      = 3'd1;
    localparam cond_t COND_N      = 3'd2;
    localparam cond_t COND_C      = 3'd3;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

    // system words are matched in full
    localparam tiny86_bus_pkg::word_t SYS_HALT = 16'h0000;
    localparam tiny86_bus_pkg::word_t SYS_NOP  = 16'h0001;

endpackage

`default_nettype wire

//--- logic/tiny86_bus_pkg.sv
`default_nettype none

package tiny86_bus_pkg;

    // data word carried on the memory bus
    typedef logic [15:0] word_t;

    // word address, one word per location
    typedef logic [15:0] addr_t;

endpackage

`default_nettype wire

//--- logic/tiny86_config.svh
`ifndef TINY86_CONFIG_SVH
`define TINY86_CONFIG_SVH

// memory depth in 16-bit words
`define TINY86_MEM_WORDS 256

// cycles from the first rd or wr to the ready pulse, at least 1
`define TINY86_MEM_WAIT 1

// first fetch address after reset
`define TINY86_RESET_PC 16'h0000

`endif
